// File: verilog/bridgePkg.sv
// shared bridge types; word transfers only, three fixed 64 MB windows starting at 0x8000_0000
package bridgePkg;

	// number of APB peripherals, one Pselx bit each
	localparam int selWidth = 3;

	// AHB transfer types that carry a transfer
	localparam logic [1:0] htransNonseq = 2'b10;
	localparam logic [1:0] htransSeq = 2'b11;

	// --------------------
	// address map
	// --------------------

	// element 0 is the rightmost entry
	localparam logic [selWidth-1:0][31:0] slaveBase = {
		32'h8800_0000,
		32'h8400_0000,
		32'h8000_0000
	};

	localparam logic [31:0] slaveSpan = 32'h0400_0000;

	// current address phase as seen by the FSM
	typedef struct packed {
		logic [31:0] addr;
		logic [31:0] wdata;
		logic write;
		logic [selWidth-1:0] sel;
	} ahbReq;

	// APB sequencer states
	typedef enum logic [2:0] {
		idle = 3'b000,
		wWait = 3'b001,
		read = 3'b010,
		write = 3'b011,
		writeP = 3'b100,
		rEnable = 3'b101,
		wEnable = 3'b110,
		wEnableP = 3'b111
	} apbState;

endpackage

// File: verilog/ahbSlaveInterface.sv
// word transfers only; the pipeline shifts every cycle, so the master must hold Haddr/Hwdata while stalled
`timescale 1ns/1ps

module ahbSlaveInterface
(
	input logic Hclk,
	input logic Hresetn,
	input logic [31:0] Haddr,
	input logic [1:0] Htrans,
	input logic Hwrite,
	input logic [31:0] Hwdata,
	input logic Hreadyin,
	output bridgePkg::ahbReq req,
	output logic [31:0] haddr1,
	output logic [31:0] haddr2,
	output logic [31:0] hwdata1,
	output logic [31:0] hwdata2,
	output logic valid,
	output logic hwriteReg
);

	logic [bridgePkg::selWidth-1:0] sel;
	logic transActive;
	logic addrHit;

	// --------------------
	// select decode
	// --------------------

	always_comb
	begin
		sel = '0;
		for (int i = 0; i < bridgePkg::selWidth; i++)
		begin
			if ((Haddr >= bridgePkg::slaveBase[i]) &&
				(Haddr < bridgePkg::slaveBase[i] + bridgePkg::slaveSpan))
			begin
				sel[i] = 1'b1;
			end
		end
	end

	assign addrHit = |sel;

	// IDLE and BUSY carry no transfer
	assign transActive = (Htrans == bridgePkg::htransNonseq) ||
		(Htrans == bridgePkg::htransSeq);

	// only an address phase sampled with Hready high is taken
	assign valid = Hreadyin && transActive && addrHit;

	assign req.addr = Haddr;
	assign req.wdata = Hwdata;
	assign req.write = Hwrite;
	assign req.sel = sel;

	// --------------------
	// address and data pipeline
	// --------------------

	// one and two cycles back, used for the pipelined write setup
	always_ff @(posedge Hclk)
	begin
		haddr1 <= Haddr;
		haddr2 <= haddr1;
		hwdata1 <= Hwdata;
		hwdata2 <= hwdata1;
	end

	// direction of the last address phase sampled with Hready high
	always_ff @(posedge Hclk)
	begin
		if (!Hresetn)
		begin
			hwriteReg <= 1'b0;
		end
		else if (Hreadyin)
		begin
			hwriteReg <= Hwrite;
		end
	end

endmodule

// File: verilog/apbFsmController.sv
// no APB wait states or errors; a pending transfer is taken only while Hreadyout is high
`timescale 1ns/1ps

module apbFsmController
(
	input logic Hclk,
	input logic Hresetn,
	input bridgePkg::ahbReq req,
	input logic [31:0] haddr1,
	input logic [31:0] haddr2,
	input logic [31:0] hwdata1,
	input logic [31:0] hwdata2,
	input logic valid,
	input logic hwriteReg,
	output logic [31:0] Paddr,
	output logic [31:0] Pwdata,
	output logic Pwrite,
	output logic Penable,
	output logic [bridgePkg::selWidth-1:0] Pselx,
	output logic Hreadyout
);

	bridgePkg::apbState state;
	bridgePkg::apbState stateNext;

	// select of the address phase one and two cycles back
	logic [bridgePkg::selWidth-1:0] sel1;
	logic [bridgePkg::selWidth-1:0] sel2;

	logic [31:0] addrNext;
	logic [31:0] wdataNext;
	logic [bridgePkg::selWidth-1:0] selNext;
	logic pwriteNext;
	logic penableNext;
	logic readyNext;

	always_ff @(posedge Hclk)
	begin
		sel1 <= req.sel;
		sel2 <= sel1;
	end

	// --------------------
	// next state and outputs
	// --------------------

	always_comb
	begin
		stateNext = bridgePkg::idle;
		addrNext = Paddr;
		wdataNext = Pwdata;
		selNext = Pselx;
		pwriteNext = Pwrite;
		penableNext = 1'b0;
		readyNext = 1'b1;
		case (state)
			bridgePkg::idle, bridgePkg::rEnable, bridgePkg::wEnable:
			begin
				selNext = '0;
				if (valid && req.write)
				begin
					// data comes one cycle later
					stateNext = bridgePkg::wWait;
				end
				else if (valid)
				begin
					stateNext = bridgePkg::read;
					addrNext = req.addr;
					selNext = req.sel;
					pwriteNext = 1'b0;
					readyNext = 1'b0;
				end
			end
			bridgePkg::wWait:
			begin
				addrNext = haddr1;
				wdataNext = req.wdata;
				selNext = sel1;
				pwriteNext = 1'b1;
				readyNext = 1'b0;
				stateNext = valid ? bridgePkg::writeP : bridgePkg::write;
			end
			bridgePkg::read:
			begin
				penableNext = 1'b1;
				stateNext = bridgePkg::rEnable;
			end
			bridgePkg::write:
			begin
				penableNext = 1'b1;
				stateNext = bridgePkg::wEnable;
			end
			bridgePkg::writeP:
			begin
				penableNext = 1'b1;
				// a pending read keeps the master stalled until its own enable
				readyNext = hwriteReg;
				stateNext = bridgePkg::wEnableP;
			end
			bridgePkg::wEnableP:
			begin
				addrNext = haddr2;
				selNext = sel2;
				readyNext = 1'b0;
				if (hwriteReg)
				begin
					wdataNext = hwdata1;
					pwriteNext = 1'b1;
					stateNext = valid ? bridgePkg::writeP : bridgePkg::write;
				end
				else
				begin
					pwriteNext = 1'b0;
					stateNext = bridgePkg::read;
				end
			end
			default:
			begin
				selNext = '0;
				stateNext = bridgePkg::idle;
			end
		endcase
	end

	// --------------------
	// registered APB side
	// --------------------

	always_ff @(posedge Hclk)
	begin
		if (!Hresetn)
		begin
			state <= bridgePkg::idle;
			Pselx <= '0;
			Penable <= 1'b0;
			Pwrite <= 1'b0;
			Hreadyout <= 1'b0;
		end
		else
		begin
			state <= stateNext;
			Pselx <= selNext;
			Penable <= penableNext;
			Pwrite <= pwriteNext;
			Hreadyout <= readyNext;
		end
	end

	always_ff @(posedge Hclk)
	begin
		Paddr <= addrNext;
		Pwdata <= wdataNext;
	end

	// --------------------
	// checks
	// --------------------

	idleWriteToWait: assert property (@(posedge Hclk) disable iff (!Hresetn)
		(state == bridgePkg::idle && valid && req.write) |=> state == bridgePkg::wWait);

	readToEnable: assert property (@(posedge Hclk) disable iff (!Hresetn)
		state == bridgePkg::read |=> state == bridgePkg::rEnable);

	// enable follows exactly one setup cycle
	enableAfterSetup: assert property (@(posedge Hclk) disable iff (!Hresetn)
		Penable |-> ($past(Pselx) != '0) && !$past(Penable));

	selectOneHot: assert property (@(posedge Hclk) disable iff (!Hresetn)
		$onehot0(Pselx));

	// write enable carries the word of the matching AHB data phase
	writeDataMatch: assert property (@(posedge Hclk) disable iff (!Hresetn)
		(Penable && Pwrite) |-> Pwdata == hwdata2);

endmodule

// File: verilog/apbRegisterBank.sv
// word-addressed register file, no wait states; index is Paddr[31:2] modulo regDepth
`timescale 1ns/1ps

module apbRegisterBank
#(
	parameter int regDepth = 16
)
(
	input logic Hclk,
	input logic Hresetn,
	input logic Psel,
	input logic Penable,
	input logic Pwrite,
	input logic [31:0] Paddr,
	input logic [31:0] Pwdata,
	output logic [31:0] Prdata
);

	localparam int idxWidth = (regDepth > 1) ? $clog2(regDepth) : 1;

	logic [31:0] mem [regDepth];
	logic [29:0] wordNum;
	logic [idxWidth-1:0] wordIdx;

	// out-of-range word numbers wrap around
	assign wordNum = Paddr[31:2] % 30'(regDepth);
	assign wordIdx = wordNum[idxWidth-1:0];

	// --------------------
	// storage
	// --------------------

	always_ff @(posedge Hclk)
	begin
		if (!Hresetn)
		begin
			for (int i = 0; i < regDepth; i++)
			begin
				mem[i] <= '0;
			end
		end
		else if (Psel && Penable && Pwrite)
		begin
			mem[wordIdx] <= Pwdata;
		end
	end

	// zero when idle so the top can mux freely
	assign Prdata = (Psel && !Pwrite) ? mem[wordIdx] : '0;

	// enable only after this bank was selected in setup
	enableNeedsSelect: assert property (@(posedge Hclk) disable iff (!Hresetn)
		Penable |-> Psel && $past(Psel));

endmodule

// File: verilog/ahbApbBridgeTop.sv
// Hresp is always OKAY and not a port; Hreadyin must be tied to Hreadyout outside
`timescale 1ns/1ps

module ahbApbBridgeTop
#(
	parameter int regDepth = 16
)
(
	input logic Hclk,
	input logic Hresetn,
	input logic [31:0] Haddr,
	input logic [1:0] Htrans,
	input logic Hwrite,
	input logic [31:0] Hwdata,
	input logic Hreadyin,
	output logic Hreadyout,
	output logic [31:0] Hrdata
);

	bridgePkg::ahbReq req;
	logic [31:0] haddr1;
	logic [31:0] haddr2;
	logic [31:0] hwdata1;
	logic [31:0] hwdata2;
	logic valid;
	logic hwriteReg;

	logic [31:0] Paddr;
	logic [31:0] Pwdata;
	logic Pwrite;
	logic Penable;
	logic [bridgePkg::selWidth-1:0] Pselx;
	logic [31:0] prdata [bridgePkg::selWidth];

	ahbSlaveInterface slaveIf_i
	(
		.Hclk(Hclk),
		.Hresetn(Hresetn),
		.Haddr(Haddr),
		.Htrans(Htrans),
		.Hwrite(Hwrite),
		.Hwdata(Hwdata),
		.Hreadyin(Hreadyin),
		.req(req),
		.haddr1(haddr1),
		.haddr2(haddr2),
		.hwdata1(hwdata1),
		.hwdata2(hwdata2),
		.valid(valid),
		.hwriteReg(hwriteReg)
	);

	apbFsmController fsm_i
	(
		.Hclk(Hclk),
		.Hresetn(Hresetn),
		.req(req),
		.haddr1(haddr1),
		.haddr2(haddr2),
		.hwdata1(hwdata1),
		.hwdata2(hwdata2),
		.valid(valid),
		.hwriteReg(hwriteReg),
		.Paddr(Paddr),
		.Pwdata(Pwdata),
		.Pwrite(Pwrite),
		.Penable(Penable),
		.Pselx(Pselx),
		.Hreadyout(Hreadyout)
	);

	// --------------------
	// peripherals
	// --------------------

	for (genvar i = 0; i < bridgePkg::selWidth; i++)
	begin : bankGen
		// each bank sees enable only while it is selected
		apbRegisterBank #(.regDepth(regDepth)) bank_i
		(
			.Hclk(Hclk),
			.Hresetn(Hresetn),
			.Psel(Pselx[i]),
			.Penable(Penable && Pselx[i]),
			.Pwrite(Pwrite),
			.Paddr(Paddr),
			.Pwdata(Pwdata),
			.Prdata(prdata[i])
		);
	end

	// read data follows the registered select
	always_comb
	begin
		Hrdata = '0;
		for (int i = 0; i < bridgePkg::selWidth; i++)
		begin
			if (Pselx[i])
			begin
				Hrdata = prdata[i];
			end
		end
	end

endmodule

// File: bench/tbAhbApbBridge.sv
// directed tests of the bridge; assumes three 64 MB windows from 0x8000_0000 and regDepth words per bank
`timescale 1ns/1ps

module tbAhbApbBridge;

	localparam int regDepth = 16;
	// about 90 transfers, none longer than 6 cycles, with a wide margin
	localparam int timeoutCycles = 2000;
	localparam logic [1:0] htransIdle = 2'b00;
	localparam logic [1:0] htransNonseq = 2'b10;
	localparam logic [1:0] htransSeq = 2'b11;

	logic Hclk = 1'b0;
	logic Hresetn;
	logic [31:0] Haddr;
	logic [1:0] Htrans;
	logic Hwrite;
	logic [31:0] Hwdata;
	logic Hreadyin;
	logic Hreadyout;
	logic [31:0] Hrdata;

	// expected contents of each bank
	logic [31:0] model [3][regDepth];

	// pending transfers, issued back to back
	logic [31:0] qAddr [$];
	logic qWrite [$];
	logic [31:0] qData [$];
	logic [1:0] qTrans [$];

	int cycleCount = 0;
	int stallCount = 0;
	int testErrors = 0;
	int totalErrors = 0;
	int testsPassed = 0;
	int testsFailed = 0;
	int unsigned seedDummy;

	always #5 Hclk = ~Hclk;

	assign Hreadyin = Hreadyout;

	ahbApbBridgeTop #(.regDepth(regDepth)) dut_i
	(
		.Hclk(Hclk),
		.Hresetn(Hresetn),
		.Haddr(Haddr),
		.Htrans(Htrans),
		.Hwrite(Hwrite),
		.Hwdata(Hwdata),
		.Hreadyin(Hreadyin),
		.Hreadyout(Hreadyout),
		.Hrdata(Hrdata)
	);

	always @(posedge Hclk)
	begin
		cycleCount <= cycleCount + 1;
		if (cycleCount >= timeoutCycles)
		begin
			$display("timeout after %0d cycles, a transfer never completed", cycleCount);
			$display("Simulation failed");
			$finish;
		end
	end

	always @(negedge Hclk)
	begin
		if (Hresetn && !Hreadyout)
			stallCount <= stallCount + 1;
	end

	// --------------------
	// AHB master
	// --------------------

	function automatic logic [31:0] wordAddr(input int periph, input int idx);
		logic [31:0] base;
		case (periph)
			0: base = 32'h8000_0000;
			1: base = 32'h8400_0000;
			default: base = 32'h8800_0000;
		endcase
		return base + (32'(idx) << 2);
	endfunction

	task automatic queueRaw(input logic [31:0] addr, input logic wr, input logic [31:0] data,
		input logic [1:0] trans);
		qAddr.push_back(addr);
		qWrite.push_back(wr);
		qData.push_back(data);
		qTrans.push_back(trans);
	endtask

	// banks keep only the word index modulo their depth
	task automatic ahbWrite(input int periph, input int idx, input logic [31:0] data,
		input logic [1:0] trans);
		model[periph][idx % regDepth] = data;
		queueRaw(wordAddr(periph, idx), 1'b1, data, trans);
	endtask

	task automatic ahbRead(input int periph, input int idx);
		queueRaw(wordAddr(periph, idx), 1'b0, model[periph][idx % regDepth], htransNonseq);
	endtask

	task automatic ahbWriteBurst();
		for (int i = 0; i < 8; i++)
			ahbWrite(i % 3, 8 + i / 3, $urandom, (i == 0) ? htransNonseq : htransSeq);
	endtask

	task automatic waitReady();
		@(negedge Hclk);
		while (!Hreadyout)
			@(negedge Hclk);
	endtask

	task automatic issuePending();
		logic prevRead;
		logic prevWrite;
		logic [31:0] prevAddr;
		logic [31:0] prevData;
		prevRead = 1'b0;
		prevWrite = 1'b0;
		prevAddr = '0;
		prevData = '0;
		@(posedge Hclk);
		for (int i = 0; i <= qAddr.size(); i++)
		begin
			// address phase of transfer i overlaps the data phase of transfer i-1
			if (i < qAddr.size())
			begin
				Haddr <= qAddr[i];
				Hwrite <= qWrite[i];
				Htrans <= qTrans[i];
			end
			else
				Htrans <= htransIdle;
			if (prevWrite)
				Hwdata <= prevData;
			waitReady();
			if (prevRead && Hrdata !== prevData)
			begin
				$display("CHECK FAILED Hrdata at %h: expected %h, got %h",
					prevAddr, prevData, Hrdata);
				testErrors++;
			end
			@(posedge Hclk);
			if (i < qAddr.size())
			begin
				prevRead = !qWrite[i] && qTrans[i] != htransIdle;
				prevWrite = qWrite[i];
				prevAddr = qAddr[i];
				prevData = qData[i];
			end
		end
		qAddr.delete();
		qWrite.delete();
		qData.delete();
		qTrans.delete();
	endtask

	// FSM is back in idle once ready stays high for three cycles
	task automatic waitQuiet();
		int highRun;
		highRun = 0;
		while (highRun < 3)
		begin
			@(negedge Hclk);
			highRun = Hreadyout ? highRun + 1 : 0;
		end
	endtask

	task automatic endTest(input string name);
		if (testErrors == 0)
		begin
			testsPassed++;
			$display("test %s: passed", name);
		end
		else
		begin
			testsFailed++;
			$display("test %s: %0d errors", name, testErrors);
		end
		totalErrors += testErrors;
		testErrors = 0;
	endtask

	// --------------------
	// tests
	// --------------------

	task automatic resetStateTest();
		int waitCycles;
		waitCycles = 0;
		@(negedge Hclk);
		while (!Hreadyout && waitCycles < 5)
		begin
			@(negedge Hclk);
			waitCycles++;
		end
		if (!Hreadyout)
		begin
			$display("Hreadyout did not rise within 5 cycles after reset");
			testErrors++;
		end
		for (int p = 0; p < 3; p++)
			ahbRead(p, 0);
		issuePending();
		endTest("reset state");
	endtask

	task automatic singleWriteReadTest();
		int idx;
		for (int p = 0; p < 3; p++)
		begin
			idx = int'($urandom % regDepth);
			ahbWrite(p, idx, $urandom, htransNonseq);
			issuePending();
			ahbRead(p, idx);
			issuePending();
		end
		endTest("single write then read");
	endtask

	task automatic pipelinedWriteTest();
		ahbWriteBurst();
		issuePending();
		for (int i = 0; i < 8; i++)
			ahbRead(i % 3, 8 + i / 3);
		issuePending();
		endTest("back-to-back writes");
	endtask

	task automatic alternatingTest();
		for (int k = 0; k < 6; k++)
		begin
			ahbWrite(k % 3, int'($urandom % regDepth), $urandom, htransNonseq);
			ahbRead((k + 1) % 3, int'($urandom % regDepth));
		end
		issuePending();
		endTest("alternating read and write");
	endtask

	task automatic unmappedIdleTest();
		int stallsBefore;
		waitQuiet();
		stallsBefore = stallCount;
		queueRaw(32'h9000_0010, 1'b1, $urandom, htransNonseq);
		queueRaw(32'h0000_0004, 1'b1, $urandom, htransNonseq);
		queueRaw(wordAddr(1, 3), 1'b1, $urandom, htransIdle);
		issuePending();
		if (stallCount != stallsBefore)
		begin
			$display("Hreadyout went low during unmapped or idle transfers");
			testErrors++;
		end
		// full sweep, every bank must still match
		for (int p = 0; p < 3; p++)
			for (int i = 0; i < regDepth; i++)
				ahbRead(p, i);
		issuePending();
		endTest("unmapped and idle transfers");
	endtask

	task automatic wrapTest();
		ahbWrite(2, regDepth + 1, $urandom, htransNonseq);
		issuePending();
		ahbRead(2, 1);
		issuePending();
		endTest("index wraparound");
	endtask

	initial
	begin
		seedDummy = $urandom(44391);
		for (int p = 0; p < 3; p++)
			for (int i = 0; i < regDepth; i++)
				model[p][i] = '0;
		Hresetn <= 1'b0;
		Haddr <= '0;
		Htrans <= htransIdle;
		Hwrite <= 1'b0;
		Hwdata <= '0;
		repeat (2) @(posedge Hclk);
		Hresetn <= 1'b1;
		resetStateTest();
		singleWriteReadTest();
		pipelinedWriteTest();
		alternatingTest();
		unmappedIdleTest();
		wrapTest();
		$display("tests passed: %0d, failed: %0d, check errors: %0d",
			testsPassed, testsFailed, totalErrors);
		if (totalErrors == 0)
			$display("Simulation completed successfully");
		else
			$display("Simulation failed");
		$finish;
	end

endmodule

// File: tb.f
verilog/bridgePkg.sv
verilog/ahbSlaveInterface.sv
verilog/apbFsmController.sv
verilog/apbRegisterBank.sv
verilog/ahbApbBridgeTop.sv
bench/tbAhbApbBridge.sv

// File: run.sh
#!/bin/sh
# build with Verilator, run, then decide pass or fail from the log
cd "$(dirname "$0")" || exit 1
verilator --binary --assert --timescale 1ns/1ps --top-module tbAhbApbBridge \
	-f tb.f -Mdir obj_dir > build.log 2>&1 \
	&& ./obj_dir/VtbAhbApbBridge > sim.log 2>&1 \
	|| { cat build.log sim.log 2>/dev/null; echo "build or run error"; exit 1; }
cat sim.log
grep -qx "Simulation completed successfully" sim.log && exit 0 || exit 1
